/* list.f */
slv_guard_pkg.sv
slv_guard_regs.sv
txn_guard.sv
slv_guard_top.sv
tb_slv_guard_sub.sv
tb_slv_guard.sv

/* Bender.yml */
package:
  name: slv_guard

sources:
  - slv_guard_pkg.sv
  - slv_guard_regs.sv
  - txn_guard.sv
  - slv_guard_top.sv
  - target: test
    files:
      - tb_slv_guard_sub.sv
      - tb_slv_guard.sv

/* tb_slv_guard.sv */
////////////////////////////////////////
// Testbench for the subordinate guard.
// Runs a table of write and read cases
// through the top level against a
// behavioral subordinate and checks bus
// responses, interrupt and registers.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_slv_guard;

  typedef struct {
    string                name;
    logic                 is_write;
    slv_guard_pkg::addr_t addr;
    slv_guard_pkg::data_t wdata;
    logic                 guard_ena;
    slv_guard_pkg::cnt_t  budget;
    int unsigned          sub_delay;
    int unsigned          count;
    logic                 expect_overrun;
  } vec_t;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    guard_ena;
  logic                    rst_stat;
  int unsigned             sub_delay;
  slv_guard_pkg::bus_req_t mgr_req;
  slv_guard_pkg::bus_rsp_t mgr_rsp;
  slv_guard_pkg::bus_req_t sub_req;
  slv_guard_pkg::bus_rsp_t sub_rsp;
  slv_guard_pkg::reg_req_t reg_req;
  slv_guard_pkg::reg_rsp_t reg_rsp;
  logic                    irq;
  logic                    rst_req;

  slv_guard_pkg::data_t model [16];
  vec_t                 vecs [6];
  int unsigned          n_vecs = 0;
  logic [31:0]          lfsr_state = 32'h8341_207f;
  int unsigned          cycles = 0;
  int unsigned          limit;

  always #2 clk = ~clk;

  slv_guard_top uut (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .guard_ena_i ( guard_ena ),
    .req_i       ( mgr_req   ),
    .rsp_o       ( mgr_rsp   ),
    .req_o       ( sub_req   ),
    .rsp_i       ( sub_rsp   ),
    .reg_req_i   ( reg_req   ),
    .reg_rsp_o   ( reg_rsp   ),
    .irq_o       ( irq       ),
    .rst_req_o   ( rst_req   ),
    .rst_stat_i  ( rst_stat  )
  );

  // The subordinate reset completes with the status pulse
  tb_slv_guard_sub i_sub (
    .clk_i   ( clk             ),
    .rst_i   ( rst || rst_stat ),
    .delay_i ( sub_delay       ),
    .req_i   ( sub_req         ),
    .rsp_o   ( sub_rsp         )
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      abort_run($sformatf("Timeout: run did not finish within %0d cycles", limit));
    end
  end

  task automatic check_data(input string name, input slv_guard_pkg::data_t exp,
                            input slv_guard_pkg::data_t act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_addr(input string name, input slv_guard_pkg::addr_t exp,
                            input slv_guard_pkg::addr_t act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %s: expected addr %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("[FAIL] %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_reg(input string name, input slv_guard_pkg::data_t exp,
                           input slv_guard_pkg::reg_rsp_t rsp);
    if (rsp.rdata !== exp) begin
      abort_run($sformatf("[FAIL] %s: expected reg %h, actual %h", name, exp, rsp.rdata));
    end
  endtask

  // Right-shifting Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic next_random(output slv_guard_pkg::data_t w);
    for (int i = 0; i < 32; i++) begin
      w[i]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic slv_guard_pkg::data_t fill_word(input int unsigned i);
    slv_guard_pkg::addr_t a;
    a = slv_guard_pkg::addr_t'(i * 4);
    return {~a, a};
  endfunction

  function automatic int unsigned word_index(input slv_guard_pkg::addr_t base,
                                             input int unsigned k);
    slv_guard_pkg::addr_t a;
    a = base + slv_guard_pkg::addr_t'(k * 4);
    return a[5:2];
  endfunction

  task automatic add_vec(input string name, input logic is_write,
                         input slv_guard_pkg::addr_t addr, input slv_guard_pkg::data_t wdata,
                         input logic ena, input slv_guard_pkg::cnt_t budget,
                         input int unsigned delay, input int unsigned count, input logic ovr);
    vecs[n_vecs].name           = name;
    vecs[n_vecs].is_write       = is_write;
    vecs[n_vecs].addr           = addr;
    vecs[n_vecs].wdata          = wdata;
    vecs[n_vecs].guard_ena      = ena;
    vecs[n_vecs].budget         = budget;
    vecs[n_vecs].sub_delay      = delay;
    vecs[n_vecs].count          = count;
    vecs[n_vecs].expect_overrun = ovr;
    n_vecs++;
  endtask

  // Single-cycle strobe with the response sampled mid-cycle one cycle later
  task automatic reg_access(input string name, input logic write, input logic [3:0] addr,
                            input slv_guard_pkg::data_t wdata,
                            output slv_guard_pkg::reg_rsp_t rsp);
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    @(posedge clk);
    #1;
    reg_req.valid = 1'b0;
    @(negedge clk);
    check_bit({name, " reg ready"}, 1'b1, reg_rsp.ready);
    rsp = reg_rsp;
    @(posedge clk);
    #1;
  endtask

  task automatic drive_txn(input logic is_write, input logic valid,
                           input slv_guard_pkg::addr_t addr, input slv_guard_pkg::data_t data);
    if (is_write) begin
      mgr_req.wr_valid = valid;
      mgr_req.wr.addr  = addr;
      mgr_req.wr.data  = data;
      mgr_req.wr.strb  = 4'hf;
    end else begin
      mgr_req.rd_valid = valid;
      mgr_req.rd.addr  = addr;
    end
  endtask

  task automatic run_entry(input vec_t v);
    slv_guard_pkg::reg_rsp_t rsp;
    slv_guard_pkg::data_t    wd;
    logic [3:0]              budget_reg;
    int unsigned             sent;
    int unsigned             got;
    logic                    irq_seen;
    logic                    stalled;
    logic                    fire;
    budget_reg = v.is_write ? slv_guard_pkg::RegBudgetWr : slv_guard_pkg::RegBudgetRd;
    guard_ena  = v.guard_ena;
    sub_delay  = v.sub_delay;
    reg_access(v.name, 1'b1, budget_reg, slv_guard_pkg::data_t'(v.budget), rsp);
    reg_access(v.name, 1'b0, budget_reg, '0, rsp);
    check_reg({v.name, " budget"}, slv_guard_pkg::data_t'(v.budget), rsp);
    wd = v.wdata;
    if (v.is_write && (wd == '0)) begin
      next_random(wd);
    end
    sent     = 0;
    got      = 0;
    irq_seen = 1'b0;
    stalled  = 1'b0;
    drive_txn(v.is_write, 1'b1, v.addr, wd);
    while ((got < v.count) && !irq_seen) begin
      @(negedge clk);
      if (irq) begin
        irq_seen = 1'b1;
      end else begin
        fire = (sent < v.count) && (v.is_write ? mgr_rsp.wr_ready : mgr_rsp.rd_ready);
        if ((sent < v.count) && !fire) begin
          stalled = 1'b1;
        end
        if (v.is_write ? mgr_rsp.b_valid : mgr_rsp.r_valid) begin
          if (!v.is_write) begin
            check_data(v.name, model[word_index(v.addr, got)], mgr_rsp.r_data);
          end
          got++;
        end
        @(posedge clk);
        #1;
        if (fire) begin
          if (v.is_write) begin
            model[word_index(v.addr, sent)] = wd;
          end
          sent++;
          drive_txn(v.is_write, sent < v.count, v.addr + slv_guard_pkg::addr_t'(4 * sent), wd);
        end
      end
    end
    // More requests than table slots must have waited for one
    if (v.count > slv_guard_pkg::MaxTxns) begin
      check_bit({v.name, " stall"}, 1'b1, stalled);
    end
    if (v.expect_overrun) begin
      check_bit({v.name, " irq"}, 1'b1, irq_seen);
      check_bit({v.name, " rst_req"}, 1'b1, rst_req);
      // Late response must stay hidden from the manager
      while (!(v.is_write ? sub_rsp.b_valid : sub_rsp.r_valid)) begin
        @(negedge clk);
      end
      check_bit({v.name, " rsp valid"}, 1'b0,
                v.is_write ? mgr_rsp.b_valid : mgr_rsp.r_valid);
      // Subordinate sees an all-zero request while isolated
      check_bit({v.name, " req isolated"}, 1'b1, sub_req === '0);
      @(posedge clk);
      #1;
      reg_access(v.name, 1'b0, slv_guard_pkg::RegStatus, '0, rsp);
      check_reg({v.name, " status"}, v.is_write ? 32'd1 : 32'd2, rsp);
      reg_access(v.name, 1'b0, slv_guard_pkg::RegIrqAddr, '0, rsp);
      check_addr(v.name, v.addr, rsp.rdata[15:0]);
      rst_stat = 1'b1;
      @(posedge clk);
      #1;
      rst_stat = 1'b0;
      @(negedge clk);
      check_bit({v.name, " irq cleared"}, 1'b0, irq);
      check_bit({v.name, " rst_req cleared"}, 1'b0, rst_req);
      @(posedge clk);
      #1;
      reg_access(v.name, 1'b1, slv_guard_pkg::RegStatus, 32'h3, rsp);
      reg_access(v.name, 1'b0, slv_guard_pkg::RegStatus, '0, rsp);
      check_reg({v.name, " status clear"}, '0, rsp);
    end else begin
      check_bit({v.name, " irq"}, 1'b0, irq_seen);
      check_bit({v.name, " rst_req"}, 1'b0, rst_req);
    end
  endtask

  initial begin
    slv_guard_pkg::reg_rsp_t rsp;
    rst              = 1'b1;
    guard_ena        = 1'b0;
    rst_stat         = 1'b0;
    sub_delay        = 0;
    mgr_req          = '0;
    mgr_req.b_ready  = 1'b1;
    mgr_req.r_ready  = 1'b1;
    reg_req          = '0;
    for (int i = 0; i < 16; i++) begin
      model[i] = fill_word(i);
    end
    // Fast delays stay under half the budget in cycles and slow ones over twice it
    add_vec("fast_write", 1'b1, 16'h0010, 32'h1234_5678, 1'b1, 12'd16, 6, 1, 1'b0);
    add_vec("fast_read", 1'b0, 16'h0010, '0, 1'b1, 12'd16, 6, 1, 1'b0);
    add_vec("slow_write", 1'b1, 16'h0024, '0, 1'b1, 12'd4, 60, 1, 1'b1);
    add_vec("slow_read", 1'b0, 16'h0018, '0, 1'b1, 12'd4, 60, 1, 1'b1);
    add_vec("unguarded_write", 1'b1, 16'h0030, '0, 1'b0, 12'd4, 60, 1, 1'b0);
    add_vec("burst_read", 1'b0, 16'h0010, '0, 1'b1, 12'd16, 6, 5, 1'b0);
    limit = 100;
    for (int i = 0; i < n_vecs; i++) begin
      limit += vecs[i].sub_delay + 40;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    reg_access("reset_status", 1'b0, slv_guard_pkg::RegStatus, '0, rsp);
    check_reg("reset_status", '0, rsp);
    for (int i = 0; i < n_vecs; i++) begin
      run_entry(vecs[i]);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_slv_guard_sub.sv */
////////////////////////////////////////
// Behavioral subordinate for the guard
// testbench. 16-word memory that answers
// every accepted write or read in order,
// delay_i cycles after acceptance.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_slv_guard_sub (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  int unsigned             delay_i,
  input  slv_guard_pkg::bus_req_t req_i,
  output slv_guard_pkg::bus_rsp_t rsp_o
);

  slv_guard_pkg::data_t mem [16];

  // Pending responses with the oldest at head
  logic                 is_wr [8];
  slv_guard_pkg::data_t rdat [8];
  int unsigned          due [8];
  int unsigned          head;
  int unsigned          tail;
  int unsigned          fill;
  int unsigned          cyc;

  logic head_due;
  logic push_wr;
  logic push_rd;
  logic pop;

  // Fill word holds the byte address and its inverse
  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] <= {~16'(i * 4), 16'(i * 4)};
    end
  end

  assign head_due       = (fill != 0) && (cyc >= due[head]);
  assign rsp_o.wr_ready = (fill < 8);
  // One new entry per cycle and writes go first
  assign rsp_o.rd_ready = (fill < 8) && !req_i.wr_valid;
  assign rsp_o.b_valid  = head_due && is_wr[head];
  assign rsp_o.r_valid  = head_due && !is_wr[head];
  assign rsp_o.r_data   = rdat[head];

  assign push_wr = req_i.wr_valid && rsp_o.wr_ready;
  assign push_rd = req_i.rd_valid && rsp_o.rd_ready;
  assign pop     = (rsp_o.b_valid && req_i.b_ready) || (rsp_o.r_valid && req_i.r_ready);

  always @(posedge clk_i) begin
    if (rst_i) begin
      head <= 0;
      tail <= 0;
      fill <= 0;
      cyc  <= 0;
    end else begin
      cyc <= cyc + 1;
      if (push_wr || push_rd) begin
        is_wr[tail] <= push_wr;
        rdat[tail]  <= mem[req_i.rd.addr[5:2]];
        due[tail]   <= cyc + delay_i;
        tail        <= (tail + 1) % 8;
      end
      if (push_wr) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.wr.strb[b]) begin
            mem[req_i.wr.addr[5:2]][8*b +: 8] <= req_i.wr.data[8*b +: 8];
          end
        end
      end
      if (pop) begin
        head <= (head + 1) % 8;
      end
      fill <= fill + ((push_wr || push_rd) ? 1 : 0) - (pop ? 1 : 0);
    end
  end

endmodule

`default_nettype wire

/* slv_guard_top.sv */
////////////////////////////////////////
// Subordinate guard top level. Sits
// between a manager and one subordinate,
// times writes and reads separately and
// cuts the subordinate off once a
// response runs past its budget.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module slv_guard_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic                    guard_ena_i,
  input  slv_guard_pkg::bus_req_t req_i,
  output slv_guard_pkg::bus_rsp_t rsp_o,
  output slv_guard_pkg::bus_req_t req_o,
  input  slv_guard_pkg::bus_rsp_t rsp_i,
  input  slv_guard_pkg::reg_req_t reg_req_i,
  output slv_guard_pkg::reg_rsp_t reg_rsp_o,
  output logic                    irq_o,
  output logic                    rst_req_o,
  input  logic                    rst_stat_i
);

  slv_guard_pkg::reg2hw_t    reg2hw;
  slv_guard_pkg::guard_evt_t wr_evt;
  slv_guard_pkg::guard_evt_t rd_evt;

  logic wr_enqueue, rd_enqueue;
  logic wr_deq, rd_deq;
  logic wr_full, rd_full;
  logic wr_overrun, rd_overrun;
  logic overrun;

  slv_guard_regs i_regs (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .reg_req_i ( reg_req_i ),
    .reg_rsp_o ( reg_rsp_o ),
    .wr_evt_i  ( wr_evt    ),
    .rd_evt_i  ( rd_evt    ),
    .reg2hw_o  ( reg2hw    )
  );

  assign overrun   = wr_overrun | rd_overrun;
  assign irq_o     = overrun;
  assign rst_req_o = overrun;

  // Bus path, combinational unless a guard intervenes
  always_comb begin : proc_output_txn
    req_o      = req_i;
    rsp_o      = rsp_i;
    wr_enqueue = 1'b0;
    rd_enqueue = 1'b0;
    if (guard_ena_i) begin
      // Hold off new requests while the table is full
      if (wr_full) begin
        req_o.wr_valid = 1'b0;
        rsp_o.wr_ready = 1'b0;
      end
      if (rd_full) begin
        req_o.rd_valid = 1'b0;
        rsp_o.rd_ready = 1'b0;
      end
      wr_enqueue = req_i.wr_valid && rsp_o.wr_ready;
      rd_enqueue = req_i.rd_valid && rsp_o.rd_ready;
      // Isolate the subordinate until its reset is reported
      if (overrun) begin
        req_o      = '0;
        rsp_o      = '0;
        wr_enqueue = 1'b0;
        rd_enqueue = 1'b0;
      end
    end
  end

  // Response transfers as seen by the manager
  assign wr_deq = rsp_o.b_valid && req_o.b_ready;
  assign rd_deq = rsp_o.r_valid && req_o.r_ready;

  txn_guard #(
    .meta_t ( slv_guard_pkg::wr_chan_t )
  ) i_write_guard (
    .clk_i         ( clk_i            ),
    .rst_i         ( rst_i            ),
    .enq_i         ( wr_enqueue       ),
    .meta_i        ( req_i.wr         ),
    .deq_i         ( wr_deq           ),
    .budget_i      ( reg2hw.budget_wr ),
    .reset_clear_i ( rst_stat_i       ),
    .full_o        ( wr_full          ),
    .overrun_o     ( wr_overrun       ),
    .evt_o         ( wr_evt           )
  );

  txn_guard #(
    .meta_t ( slv_guard_pkg::rd_chan_t )
  ) i_read_guard (
    .clk_i         ( clk_i            ),
    .rst_i         ( rst_i            ),
    .enq_i         ( rd_enqueue       ),
    .meta_i        ( req_i.rd         ),
    .deq_i         ( rd_deq           ),
    .budget_i      ( reg2hw.budget_rd ),
    .reset_clear_i ( rst_stat_i       ),
    .full_o        ( rd_full          ),
    .overrun_o     ( rd_overrun       ),
    .evt_o         ( rd_evt           )
  );

endmodule

`default_nettype wire

/* txn_guard.sv */
////////////////////////////////////////
// Latency guard for one bus direction.
// Tracks accepted requests in order,
// ages the oldest in prescaled ticks and
// flags it once it exceeds the budget.
// Instantiate once per direction with
// that direction's channel payload.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module txn_guard #(
  // Channel payload, needs an addr field
  parameter type meta_t = slv_guard_pkg::rd_chan_t
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      enq_i,
  input  meta_t                     meta_i,
  input  logic                      deq_i,
  input  slv_guard_pkg::cnt_t       budget_i,
  input  logic                      reset_clear_i,
  output logic                      full_o,
  output logic                      overrun_o,
  output slv_guard_pkg::guard_evt_t evt_o
);

  typedef struct packed {
    slv_guard_pkg::cnt_t  start;
    slv_guard_pkg::addr_t addr;
  } entry_t;

  slv_guard_pkg::pre_t  pre_q;
  logic                 tick;
  slv_guard_pkg::cnt_t  now_q;

  entry_t [slv_guard_pkg::MaxTxns-1:0] txn_q;
  slv_guard_pkg::ptr_t  head_q;
  slv_guard_pkg::ptr_t  tail_q;
  slv_guard_pkg::fill_t fill_q;

  logic                 push;
  logic                 pop;
  logic                 busy;
  slv_guard_pkg::cnt_t  age;
  logic                 detect;
  logic                 overrun_q;

  function automatic slv_guard_pkg::ptr_t ptr_next(input slv_guard_pkg::ptr_t p);
    return (p == slv_guard_pkg::PtrLast) ? '0 : p + 1'b1;
  endfunction

  // Prescaler and free-running tick counter
  assign tick = (pre_q == slv_guard_pkg::PreLast);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pre_q <= '0;
      now_q <= '0;
    end else if (tick) begin
      pre_q <= '0;
      now_q <= now_q + 1'b1;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  assign busy   = (fill_q != '0);
  assign full_o = (fill_q == slv_guard_pkg::FillMax);
  assign push   = enq_i && !full_o;
  assign pop    = deq_i && busy;

  // Entry payload, written at the tail
  always_ff @(posedge clk_i) begin
    if (push) begin
      txn_q[tail_q].start <= now_q;
      txn_q[tail_q].addr  <= meta_i.addr;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || reset_clear_i) begin
      head_q <= '0;
      tail_q <= '0;
      fill_q <= '0;
    end else begin
      if (push) begin
        tail_q <= ptr_next(tail_q);
      end
      if (pop) begin
        head_q <= ptr_next(head_q);
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  // Head is always the oldest entry; modulo age survives counter wrap
  assign age    = now_q - txn_q[head_q].start;
  assign detect = busy && (age > budget_i) && !overrun_q;

  always_ff @(posedge clk_i) begin
    if (rst_i || reset_clear_i) begin
      overrun_q <= 1'b0;
    end else if (detect) begin
      overrun_q <= 1'b1;
    end
  end

  assign overrun_o     = overrun_q;
  assign evt_o.overrun = detect;
  assign evt_o.addr    = txn_q[head_q].addr;

endmodule

`default_nettype wire

/* slv_guard_regs.sv */
////////////////////////////////////////
// Configuration and status registers
// of the subordinate guard. Accesses on
// the register bus answer one cycle
// after the request strobe.
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module slv_guard_regs (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  slv_guard_pkg::reg_req_t   reg_req_i,
  output slv_guard_pkg::reg_rsp_t   reg_rsp_o,
  input  slv_guard_pkg::guard_evt_t wr_evt_i,
  input  slv_guard_pkg::guard_evt_t rd_evt_i,
  output slv_guard_pkg::reg2hw_t    reg2hw_o
);

  slv_guard_pkg::reg2hw_t budget_q;
  logic [1:0]             status_q;
  logic [1:0]             status_clr;
  slv_guard_pkg::addr_t   irq_addr_q;
  logic                   ready_q;
  slv_guard_pkg::data_t   rdata_q;
  slv_guard_pkg::data_t   rdata_d;
  logic                   wr_acc;

  assign wr_acc = reg_req_i.valid && reg_req_i.write;

  // Write one to clear
  assign status_clr = (wr_acc && (reg_req_i.addr == slv_guard_pkg::RegStatus)) ?
                      reg_req_i.wdata[1:0] : 2'b00;

  // Read mux, unknown offsets give zero
  always_comb begin
    rdata_d = '0;
    if (!reg_req_i.write) begin
      case (reg_req_i.addr)
        slv_guard_pkg::RegBudgetWr: rdata_d = slv_guard_pkg::data_t'(budget_q.budget_wr);
        slv_guard_pkg::RegBudgetRd: rdata_d = slv_guard_pkg::data_t'(budget_q.budget_rd);
        slv_guard_pkg::RegStatus:   rdata_d = slv_guard_pkg::data_t'(status_q);
        slv_guard_pkg::RegIrqAddr:  rdata_d = slv_guard_pkg::data_t'(irq_addr_q);
        default:                    rdata_d = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      budget_q.budget_wr <= slv_guard_pkg::BudgetRst;
      budget_q.budget_rd <= slv_guard_pkg::BudgetRst;
    end else if (wr_acc) begin
      if (reg_req_i.addr == slv_guard_pkg::RegBudgetWr) begin
        budget_q.budget_wr <= slv_guard_pkg::cnt_t'(reg_req_i.wdata);
      end
      if (reg_req_i.addr == slv_guard_pkg::RegBudgetRd) begin
        budget_q.budget_rd <= slv_guard_pkg::cnt_t'(reg_req_i.wdata);
      end
    end
  end

  // Sticky status, a new event beats a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      status_q   <= 2'b00;
      irq_addr_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | {rd_evt_i.overrun, wr_evt_i.overrun};
      if (wr_evt_i.overrun) begin
        irq_addr_q <= wr_evt_i.addr;
      end else if (rd_evt_i.overrun) begin
        irq_addr_q <= rd_evt_i.addr;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= reg_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i.valid) begin
      rdata_q <= rdata_d;
    end
  end

  assign reg_rsp_o.ready = ready_q;
  assign reg_rsp_o.rdata = rdata_q;
  assign reg2hw_o        = budget_q;

endmodule

`default_nettype wire

/* slv_guard_pkg.sv */
////////////////////////////////////////
// Shared types and constants for the
// subordinate guard. Every design file
// refers to these by scoped name.
////////////////////////////////////////

`default_nettype none

package slv_guard_pkg;

  // Guard sizing
  localparam int unsigned CntWidth     = 12;
  localparam int unsigned MaxTxns      = 4;
  localparam int unsigned PrescalerDiv = 4;
  localparam int unsigned PtrWidth     = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  localparam int unsigned PreWidth     = (PrescalerDiv > 1) ? $clog2(PrescalerDiv) : 1;

  typedef logic [15:0]         addr_t;
  typedef logic [31:0]         data_t;
  typedef logic [3:0]          strb_t;
  typedef logic [CntWidth-1:0] cnt_t;
  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [PtrWidth:0]   fill_t;
  typedef logic [PreWidth-1:0] pre_t;

  localparam ptr_t  PtrLast   = ptr_t'(MaxTxns - 1);
  localparam fill_t FillMax   = fill_t'(MaxTxns);
  localparam pre_t  PreLast   = pre_t'(PrescalerDiv - 1);
  localparam cnt_t  BudgetRst = cnt_t'(12'h010);

  // Register map, byte offsets
  localparam logic [3:0] RegBudgetWr = 4'h0;
  localparam logic [3:0] RegBudgetRd = 4'h4;
  localparam logic [3:0] RegStatus   = 4'h8;
  localparam logic [3:0] RegIrqAddr  = 4'hC;

  // Write address and data share one channel
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } wr_chan_t;

  typedef struct packed {
    addr_t addr;
  } rd_chan_t;

  typedef struct packed {
    logic     wr_valid;
    wr_chan_t wr;
    logic     rd_valid;
    rd_chan_t rd;
    logic     b_ready;
    logic     r_ready;
  } bus_req_t;

  typedef struct packed {
    logic  wr_ready;
    logic  rd_ready;
    logic  b_valid;
    logic  r_valid;
    data_t r_data;
  } bus_rsp_t;

  typedef struct packed {
    logic       valid;
    logic       write;
    logic [3:0] addr;
    data_t      wdata;
  } reg_req_t;

  typedef struct packed {
    logic  ready;
    data_t rdata;
  } reg_rsp_t;

  typedef struct packed {
    cnt_t budget_wr;
    cnt_t budget_rd;
  } reg2hw_t;

  typedef struct packed {
    logic  overrun;
    addr_t addr;
  } guard_evt_t;

endpackage

`default_nettype wire
